// ==== Bender.yml ====
package:
  name: agu_replay_cam

sources:
  - agu_replay_pkg.sv
  - replay_store_if.sv
  - replay_ctrl.sv
  - replay_lane.sv
  - replay_pick.sv
  - agu_replay_cam.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - tb_agu_replay_cam.sv

// ==== agu_replay_cam.sv ====
`timescale 1ns/100ps

module agu_replay_cam import agu_replay_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  lane_mask_t in_conflict,
  input  mop_t       in_mop0,
  input  mop_t       in_mop1,
  input  mop_t       in_mop2,
  input  logic       read_en,
  input  logic       rs_stall,
  input  logic       except,
  output logic       out_en,
  output mop_t       out_mop,
  output lane_idx_t  out_lane,
  output logic       skip
);

  // incoming words gathered by lane number
  mop_t lane_mop [LANE_COUNT];

  assign lane_mop[0] = in_mop0;
  assign lane_mop[1] = in_mop1;
  assign lane_mop[2] = in_mop2;

  replay_store_if st ();

  // pointers, valid bits, occupancy and skip
  replay_ctrl i_replay_ctrl (
    .clk         (clk),
    .rst         (rst),
    .in_conflict (in_conflict),
    .except      (except),
    .skip        (skip),
    .st          (st.ctrl)
  );

  // one store per lane
  for (genvar k = 0; k < LANE_COUNT; k++) begin : g_lane
    replay_lane #(
      .LANE (k)
    ) i_replay_lane (
      .clk    (clk),
      .mop_in (lane_mop[k]),
      .st     (st.lane)
    );
  end

  // lane select and replay output
  replay_pick i_replay_pick (
    .clk      (clk),
    .rst      (rst),
    .read_en  (read_en),
    .rs_stall (rs_stall),
    .except   (except),
    .out_en   (out_en),
    .out_mop  (out_mop),
    .out_lane (out_lane),
    .st       (st.pick)
  );

endmodule

// ==== agu_replay_pkg.sv ====
package agu_replay_pkg;

  // micro-op lanes arriving per cycle
  localparam int unsigned LANE_COUNT = 3;

  // lane number width
  localparam int unsigned LANE_IDX_W = 2;

  // replay ring size and its pointer width
  localparam int unsigned DEPTH = 8;
  localparam int unsigned PTR_W = 3;

  // opaque micro-op word
  localparam int unsigned MOP_W = 64;

  // occupancy that raises skip towards upstream
  localparam int unsigned STALL_COUNT = 4;

  // occupancy counter must hold DEPTH itself
  localparam int unsigned COUNT_W = 4;

  typedef logic [PTR_W-1:0] ptr_t;

  typedef logic [COUNT_W-1:0] count_t;

  // packed as address 44, lsq slot 9, register 6, size 5
  // the queue only stores and forwards it
  typedef logic [MOP_W-1:0] mop_t;

  // one bit per lane, bit k is lane k
  typedef logic [LANE_COUNT-1:0] lane_mask_t;

  typedef logic [LANE_IDX_W-1:0] lane_idx_t;

endpackage

// ==== flist.f ====
agu_replay_pkg.sv
replay_store_if.sv
replay_ctrl.sv
replay_lane.sv
replay_pick.sv
agu_replay_cam.sv
tb_clock_gen.sv
tb_agu_replay_cam.sv

// ==== replay_ctrl.sv ====
`timescale 1ns/100ps

module replay_ctrl import agu_replay_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  lane_mask_t   in_conflict,
  input  logic         except,
  output logic         skip,
  replay_store_if.ctrl st
);

  // one valid bit per ring entry
  logic [DEPTH-1:0] valid;

  ptr_t   wr_ptr;
  ptr_t   rd_ptr;
  count_t count;

  logic capture;
  logic retire;

  // store only when some lane conflicted
  // an exception in the same cycle drops the capture
  assign capture = (|in_conflict) && !except;

  // pop comes from the picker once the last lane is out
  assign retire = st.pop;

  assign st.wr_en       = capture;
  assign st.wr_ptr      = wr_ptr;
  assign st.wr_conflict = except ? '0 : in_conflict;
  assign st.rd_ptr      = rd_ptr;
  assign st.head_valid  = valid[rd_ptr];

  // write pointer
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
    end else if (capture) begin
      wr_ptr <= ptr_t'(wr_ptr + 1'b1);
    end
  end

  // read pointer, jumps to the write pointer on a flush
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
    end else if (except) begin
      rd_ptr <= wr_ptr;
    end else if (retire) begin
      rd_ptr <= ptr_t'(rd_ptr + 1'b1);
    end
  end

  // entry valid bits
  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
    end else if (except) begin
      valid <= '0;
    end else begin
      if (retire) begin
        valid[rd_ptr] <= 1'b0;
      end
      if (capture) begin
        valid[wr_ptr] <= 1'b1;
      end
    end
  end

  // occupancy, up on capture and down on retire
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (except) begin
      count <= '0;
    end else begin
      case ({capture, retire})
        2'b10: count <= count_t'(count + 1'b1);
        2'b01: count <= count_t'(count - 1'b1);
        default: count <= count;
      endcase
    end
  end

  // skip hysteresis
  // set once STALL_COUNT entries are held, cleared only when empty
  always_ff @(posedge clk) begin
    if (rst) begin
      skip <= 1'b0;
    end else if (count >= count_t'(STALL_COUNT)) begin
      skip <= 1'b1;
    end else if (count == '0) begin
      skip <= 1'b0;
    end
  end

endmodule

// ==== replay_lane.sv ====
`timescale 1ns/100ps

module replay_lane import agu_replay_pkg::*; #(
  parameter int unsigned LANE = 0
) (
  input  logic         clk,
  input  mop_t         mop_in,
  replay_store_if.lane st
);

  // micro-op words of this lane, one per ring entry
  mop_t mem [DEPTH];

  // stored conflict bit of this lane per entry
  logic [DEPTH-1:0] confl;

  // capture edge
  // a zero conflict bit is stored too so an old entry cannot leak through
  always_ff @(posedge clk) begin
    if (st.wr_en) begin
      mem[st.wr_ptr]   <= mop_in;
      confl[st.wr_ptr] <= st.wr_conflict[LANE];
    end
  end

  // head entry read, stale data is masked by head_valid in the picker
  assign st.rd_conflict[LANE] = confl[st.rd_ptr];
  assign st.rd_mop[LANE]      = mem[st.rd_ptr];

endmodule

// ==== replay_pick.sv ====
`timescale 1ns/100ps

module replay_pick import agu_replay_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  logic         read_en,
  input  logic         rs_stall,
  input  logic         except,
  output logic         out_en,
  output mop_t         out_mop,
  output lane_idx_t    out_lane,
  replay_store_if.pick st
);

  // lanes of the head entry not yet replayed
  lane_mask_t lane_mask;

  lane_mask_t pending;
  lane_mask_t sel_bit;
  lane_mask_t remain;
  lane_idx_t  sel;
  logic       found;
  logic       step;

  // conflicting lanes still waiting in the head entry
  assign pending = st.head_valid ? (st.rd_conflict & lane_mask) : '0;

  // lowest pending lane goes first
  always_comb begin
    sel   = '0;
    found = 1'b0;
    for (int k = LANE_COUNT - 1; k >= 0; k--) begin
      if (pending[k]) begin
        sel   = lane_idx_t'(k);
        found = 1'b1;
      end
    end
  end

  assign sel_bit = lane_mask_t'(1) << sel;
  assign remain  = pending & ~sel_bit;

  // one op consumed per edge with step high
  assign step = found && read_en && !rs_stall && !except;

  assign out_en   = step;
  assign out_mop  = st.rd_mop[sel];
  assign out_lane = sel;

  // retire with the last pending lane
  assign st.pop = step && (remain == '0);

  // lane mask, reopened for every new head entry
  always_ff @(posedge clk) begin
    if (rst) begin
      lane_mask <= '1;
    end else if (except || st.pop) begin
      lane_mask <= '1;
    end else if (step) begin
      lane_mask <= lane_mask & ~sel_bit;
    end
  end

endmodule

// ==== replay_store_if.sv ====
`timescale 1ns/100ps

interface replay_store_if import agu_replay_pkg::*; ();

  // write side, from the pointer controller
  logic       wr_en;
  ptr_t       wr_ptr;
  lane_mask_t wr_conflict;

  // head entry pointer and its valid bit
  ptr_t rd_ptr;
  logic head_valid;

  // head entry contents, each lane store drives its own slice
  wire lane_mask_t rd_conflict;
  wire mop_t       rd_mop [LANE_COUNT];

  // retire strobe for the head entry
  logic pop;

  modport ctrl (
    output wr_en,
    output wr_ptr,
    output wr_conflict,
    output rd_ptr,
    output head_valid,
    input  pop
  );

  modport lane (
    input  wr_en,
    input  wr_ptr,
    input  wr_conflict,
    input  rd_ptr,
    output rd_conflict,
    output rd_mop
  );

  modport pick (
    input  head_valid,
    input  rd_conflict,
    input  rd_mop,
    output pop
  );

endinterface

// ==== tb_agu_replay_cam.sv ====
`timescale 1ns/100ps

module tb_agu_replay_cam import agu_replay_pkg::*; ();

  // expected replay, lane number above the word
  typedef logic [LANE_IDX_W+MOP_W-1:0] pair_t;
  typedef pair_t pair_q_t [$];

  logic       clk;
  logic       rst;
  lane_mask_t in_conflict;
  mop_t       in_mop0;
  mop_t       in_mop1;
  mop_t       in_mop2;
  logic       read_en;
  logic       rs_stall;
  logic       except;
  logic       out_en;
  mop_t       out_mop;
  lane_idx_t  out_lane;
  logic       skip;

  integer  seed = 61;
  string   test_name = "reset";
  pair_q_t model;
  logic    quiet;
  logic    watch_skip;

  tb_clock_gen i_tb_clock_gen (
    .clk (clk),
    .rst (rst)
  );

  agu_replay_cam i_agu_replay_cam (
    .clk         (clk),
    .rst         (rst),
    .in_conflict (in_conflict),
    .in_mop0     (in_mop0),
    .in_mop1     (in_mop1),
    .in_mop2     (in_mop2),
    .read_en     (read_en),
    .rs_stall    (rs_stall),
    .except      (except),
    .out_en      (out_en),
    .out_mop     (out_mop),
    .out_lane    (out_lane),
    .skip        (skip)
  );

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic fail_now(input string msg);
    $display("%s (test %s)", msg, test_name);
    abort_run();
  endtask

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("ERR %s %s: expected %0h actual %0h", test_name, what, expected, actual);
      abort_run();
    end
  endtask

  // lanes of one captured entry, lowest lane first
  function automatic pair_q_t expect_pairs(input lane_mask_t mask, input mop_t w0,
                                           input mop_t w1, input mop_t w2);
    pair_q_t q;
    mop_t    words [LANE_COUNT];
    words[0] = w0;
    words[1] = w1;
    words[2] = w2;
    for (int k = 0; k < LANE_COUNT; k++) begin
      if (mask[k]) begin
        q.push_back({lane_idx_t'(k), words[k]});
      end
    end
    return q;
  endfunction

  // reference model update and output compare
  always @(posedge clk) begin : monitor
    pair_t   exp_pair;
    pair_q_t new_pairs;
    if (!rst) begin
      if (out_en) begin
        if (quiet) begin
          fail_now("out_en seen in a window where nothing may replay");
        end else if (rs_stall || !read_en) begin
          fail_now("out_en seen while replay was held back");
        end else if (model.size() == 0) begin
          fail_now("out_en seen with no op left in the reference model");
        end else begin
          exp_pair = model.pop_front();
          check_value("lane", exp_pair[MOP_W +: LANE_IDX_W], out_lane);
          check_value("mop", exp_pair[MOP_W-1:0], out_mop);
        end
      end
      if (watch_skip && !skip && model.size() != 0) begin
        fail_now("skip fell while entries were still queued");
      end
      if (skip && in_conflict != '0 && !except) begin
        fail_now("upstream sent a capture while skip was high");
      end
      if (except) begin
        model.delete();
      end else if (in_conflict != '0) begin
        new_pairs = expect_pairs(in_conflict, in_mop0, in_mop1, in_mop2);
        foreach (new_pairs[i]) begin
          model.push_back(new_pairs[i]);
        end
      end
    end
  end

  function automatic lane_mask_t rand_mask();
    return lane_mask_t'($random(seed));
  endfunction

  function automatic lane_mask_t rand_mask_nz();
    lane_mask_t m;
    m = rand_mask();
    if (m == '0) begin
      m = lane_mask_t'(1);
    end
    return m;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  // upstream pauses while skip is high
  task automatic send(input lane_mask_t mask);
    in_conflict = skip ? '0 : mask;
    in_mop0     = {$random(seed), $random(seed)};
    in_mop1     = {$random(seed), $random(seed)};
    in_mop2     = {$random(seed), $random(seed)};
  endtask

  task automatic wait_reset(input int limit);
    int n;
    n = 0;
    next_cycle();
    while (rst) begin
      if (n == limit) fail_now("timeout waiting for reset to end");
      next_cycle();
      n++;
    end
  endtask

  task automatic wait_skip_high(input int limit);
    int n;
    n = 0;
    while (!skip) begin
      if (n == limit) fail_now("timeout waiting for skip to rise");
      next_cycle();
      n++;
    end
  endtask

  task automatic wait_drained(input int limit);
    int n;
    n = 0;
    while (model.size() != 0 || skip) begin
      if (n == limit) fail_now("timeout waiting for the queue to drain and skip to fall");
      next_cycle();
      n++;
    end
  endtask

  initial begin
    int mode;
    int stretch;
    in_conflict = '0;
    in_mop0     = '0;
    in_mop1     = '0;
    in_mop2     = '0;
    read_en     = 1'b0;
    rs_stall    = 1'b0;
    except      = 1'b0;
    quiet       = 1'b0;
    watch_skip  = 1'b0;
    wait_reset(20);
    check_value("skip after reset", 0, skip);
    check_value("out_en after reset", 0, out_en);

    // random masks, zero masks included
    test_name = "order";
    read_en = 1'b1;
    repeat (60) begin
      next_cycle();
      send(rand_mask());
    end
    next_cycle();
    send('0);
    wait_drained(200);

    // random stall and read_en stretches
    test_name = "backpressure";
    stretch = 0;
    repeat (100) begin
      next_cycle();
      if (stretch == 0) begin
        mode     = $random(seed) & 3;
        stretch  = 1 + ($random(seed) & 7);
        rs_stall = (mode == 2);
        read_en  = (mode != 3);
      end
      stretch--;
      send(rand_mask());
    end
    next_cycle();
    rs_stall = 1'b0;
    read_en  = 1'b1;
    send('0);
    wait_drained(200);

    // four entries held with replay off
    test_name = "skip";
    read_en = 1'b0;
    repeat (4) begin
      next_cycle();
      send(rand_mask_nz());
    end
    next_cycle();
    send('0);
    wait_skip_high(10);
    watch_skip = 1'b1;
    read_en    = 1'b1;
    wait_drained(100);
    watch_skip = 1'b0;

    // flush with a capture in the same cycle
    test_name = "except";
    read_en = 1'b0;
    repeat (3) begin
      next_cycle();
      send(rand_mask_nz());
    end
    next_cycle();
    send(rand_mask_nz());
    except = 1'b1;
    next_cycle();
    except = 1'b0;
    send('0);
    quiet   = 1'b1;
    read_en = 1'b1;
    repeat (10) next_cycle();
    quiet = 1'b0;
    repeat (6) begin
      next_cycle();
      send(rand_mask());
    end
    next_cycle();
    send('0);
    wait_drained(100);

    test_name = "drain";
    wait_drained(100);
    quiet = 1'b1;
    repeat (20) next_cycle();
    quiet = 1'b0;
    $display("PASS: all tests");
    $finish;
  end

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // reset held for five rising edges
  initial begin
    rst = 1'b1;
    repeat (5) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule
